// ==== cache_pkg.sv ====
package cache_pkg;

    // Word address and word size
    localparam int ADDR_WIDTH    = 30;
    localparam int DATA_WIDTH    = 32;
    localparam int BYTE_EN_WIDTH = 4;

    // Miss sequencer states
    typedef enum logic [2:0] {
        ST_NORMAL       = 3'd0,
        ST_IC_MISS      = 3'd1,
        ST_DC_MISS      = 3'd2,
        ST_DOUBLE_MISS  = 3'd3,
        ST_DC_WRITEBACK = 3'd4
    } cache_state_t;

endpackage

// ==== cache_2ways.sv ====
`timescale 1ns/1ps

module cache_2ways #(
    parameter int  OFFSET_WIDTH = 3,
    parameter int  INDEX_WIDTH  = 6,
    localparam int TAG_WIDTH    = cache_pkg::ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                enable,
    input  logic                                cmp,
    input  logic                                write,
    input  logic [INDEX_WIDTH-1:0]              index,
    input  logic [OFFSET_WIDTH-1:0]             word_sel,
    input  logic [TAG_WIDTH-1:0]                tag_in,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    data_in,
    input  logic                                valid_in,
    input  logic [cache_pkg::BYTE_EN_WIDTH-1:0] byte_w_en,
    output logic                                hit,
    output logic                                dirty,
    output logic [TAG_WIDTH-1:0]                tag_out,
    output logic [cache_pkg::DATA_WIDTH-1:0]    data_out,
    output logic                                valid
);

    localparam int SETS  = 1 << INDEX_WIDTH;
    localparam int WORDS = SETS << OFFSET_WIDTH;

    //////////////////////////////
    // Storage
    //////////////////////////////

    logic [TAG_WIDTH-1:0]             tag_mem  [2][SETS];
    logic [cache_pkg::DATA_WIDTH-1:0] data_mem [2][WORDS];
    logic [SETS-1:0][1:0]             valid_q;
    logic [SETS-1:0][1:0]             dirty_q;
    // Way to replace next in each set
    logic [SETS-1:0]                  lru_q;

    logic [1:0]                          way_match;
    logic                                any_match;
    logic                                way;
    logic                                do_write;
    logic [INDEX_WIDTH+OFFSET_WIDTH-1:0] word_addr;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    assign word_addr = {index, word_sel};

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = valid_q[index][w] && (tag_mem[w][index] == tag_in);
        end
    end

    assign any_match = |way_match;
    // Compare follows the hitting way, a miss or a fill points at the victim
    assign way       = (cmp && any_match) ? way_match[1] : lru_q[index];
    assign hit       = enable && cmp && any_match;
    // Compare writes only land on a hit
    assign do_write  = enable && write && (!cmp || any_match);

    assign valid    = valid_q[index][way];
    assign dirty    = dirty_q[index][way];
    assign tag_out  = tag_mem[way][index];
    assign data_out = data_mem[way][word_addr];

    //////////////////////////////
    // Update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < cache_pkg::BYTE_EN_WIDTH; b++) begin
                if (byte_w_en[b]) begin
                    data_mem[way][word_addr][8*b +: 8] <= data_in[8*b +: 8];
                end
            end
            // Tag is taken with every refill word
            if (!cmp) begin
                tag_mem[way][index] <= tag_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (do_write) begin
                if (cmp) begin
                    dirty_q[index][way] <= 1'b1;
                end else begin
                    valid_q[index][way] <= valid_in;
                    dirty_q[index][way] <= 1'b0;
                end
            end
            // The other way becomes the victim
            if (hit) begin
                lru_q[index] <= ~way;
            end
        end
    end

    // Missed store leaves both ways of the word untouched
    assert property (@(posedge clk) disable iff (rst)
        enable && write && cmp && !any_match |=>
            (data_mem[0][$past(word_addr)] == $past(data_mem[0][word_addr])) &&
            (data_mem[1][$past(word_addr)] == $past(data_mem[1][word_addr])));

endmodule

// ==== cache_control.sv ====
`timescale 1ns/1ps

module cache_control #(
    parameter int OFFSET_WIDTH = 3
) (
    input  logic                                dc_read_in,
    input  logic                                dc_write_in,
    input  logic [cache_pkg::BYTE_EN_WIDTH-1:0] dc_byte_w_en_in,
    input  logic [OFFSET_WIDTH-1:0]             ic_offset,
    input  logic [OFFSET_WIDTH-1:0]             dc_offset,
    input  logic                                ic_hit,
    input  logic                                ic_valid,
    input  logic                                dc_hit,
    input  logic                                dc_dirty,
    input  logic                                dc_valid,
    input  cache_pkg::cache_state_t             state,
    input  logic [OFFSET_WIDTH-1:0]             counter,
    // Instruction cache
    output logic                                ic_enable,
    output logic [OFFSET_WIDTH-1:0]             ic_word_sel,
    output logic                                ic_cmp,
    output logic                                ic_write,
    output logic                                ic_data_sel,
    output logic [cache_pkg::BYTE_EN_WIDTH-1:0] ic_byte_w_en,
    output logic                                ic_valid_in,
    // Data cache
    output logic                                dc_enable,
    output logic [OFFSET_WIDTH-1:0]             dc_word_sel,
    output logic                                dc_cmp,
    output logic                                dc_write,
    output logic                                dc_data_sel,
    output logic [cache_pkg::BYTE_EN_WIDTH-1:0] dc_byte_w_en,
    output logic                                dc_valid_in,
    // RAM port and sequencer
    output logic [1:0]                          ram_addr_sel,
    output logic                                ram_en_out,
    output logic                                ram_write_out,
    output cache_pkg::cache_state_t             state_next,
    output logic [OFFSET_WIDTH-1:0]             counter_next
);

    // RAM address sources
    localparam logic [1:0] RAM_ADDR_IC = 2'b00;
    localparam logic [1:0] RAM_ADDR_DC = 2'b01;
    localparam logic [1:0] RAM_ADDR_WB = 2'b10;

    logic last_word;
    logic dc_req;
    logic ic_miss;
    logic dc_miss;

    assign last_word = (counter == {OFFSET_WIDTH{1'b1}});
    assign dc_req    = dc_read_in || dc_write_in;
    assign ic_miss   = !ic_hit;
    assign dc_miss   = dc_req && !dc_hit;

    always_comb begin
        // Hit path unless a miss state overrides
        ic_enable     = 1'b1;
        ic_word_sel   = ic_offset;
        ic_cmp        = 1'b1;
        ic_write      = 1'b0;
        ic_data_sel   = 1'b1;
        ic_byte_w_en  = '1;
        ic_valid_in   = 1'b1;
        dc_enable     = dc_req;
        dc_word_sel   = dc_offset;
        dc_cmp        = 1'b1;
        dc_write      = dc_write_in;
        dc_data_sel   = 1'b0;
        dc_byte_w_en  = dc_byte_w_en_in;
        dc_valid_in   = 1'b1;
        ram_addr_sel  = RAM_ADDR_IC;
        ram_en_out    = 1'b0;
        ram_write_out = 1'b0;
        state_next    = state;
        counter_next  = counter + 1'b1;

        case (state)
            cache_pkg::ST_NORMAL: begin
                counter_next = '0;
                if (ic_miss && dc_miss) begin
                    state_next = cache_pkg::ST_DOUBLE_MISS;
                end else if (ic_miss) begin
                    state_next = cache_pkg::ST_IC_MISS;
                end else if (dc_miss && dc_valid && dc_dirty) begin
                    state_next = cache_pkg::ST_DC_WRITEBACK;
                end else if (dc_miss) begin
                    state_next = cache_pkg::ST_DC_MISS;
                end
            end

            cache_pkg::ST_IC_MISS, cache_pkg::ST_DOUBLE_MISS: begin
                // Data cache looks up the instruction block, a hit feeds the fill
                ic_word_sel = counter;
                ic_cmp      = 1'b0;
                ic_write    = 1'b1;
                ic_data_sel = !dc_hit;
                ic_valid_in = last_word;
                dc_enable   = 1'b1;
                dc_word_sel = counter;
                dc_write    = 1'b0;
                ram_en_out  = !dc_hit;
                // data side of a double miss is judged again from normal
                if (last_word) begin
                    state_next = cache_pkg::ST_NORMAL;
                end
            end

            cache_pkg::ST_DC_WRITEBACK: begin
                ic_enable     = 1'b0;
                dc_enable     = 1'b1;
                dc_word_sel   = counter;
                dc_cmp        = 1'b0;
                dc_write      = 1'b0;
                ram_addr_sel  = RAM_ADDR_WB;
                ram_en_out    = 1'b1;
                ram_write_out = 1'b1;
                if (last_word) begin
                    state_next = cache_pkg::ST_DC_MISS;
                end
            end

            cache_pkg::ST_DC_MISS: begin
                ic_enable    = 1'b0;
                dc_enable    = 1'b1;
                dc_word_sel  = counter;
                dc_cmp       = 1'b0;
                dc_write     = 1'b1;
                dc_data_sel  = 1'b1;
                dc_byte_w_en = '1;
                dc_valid_in  = last_word;
                ram_addr_sel = RAM_ADDR_DC;
                ram_en_out   = 1'b1;
                if (last_word) begin
                    state_next = cache_pkg::ST_NORMAL;
                end
            end

            default: begin
                state_next = cache_pkg::ST_NORMAL;
            end
        endcase
    end

    // RAM writes only drain a valid dirty victim
    always_comb begin
        assert final (!ram_write_out || (ram_en_out && dc_valid && dc_dirty));
    end

endmodule

// ==== cache_manage_unit.sv ====
`timescale 1ns/1ps

module cache_manage_unit #(
    parameter int  OFFSET_WIDTH = 3,
    parameter int  INDEX_WIDTH  = 6,
    localparam int TAG_WIDTH    = cache_pkg::ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]    ic_addr,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]    dc_addr,
    input  logic                                dc_read_in,
    input  logic                                dc_write_in,
    input  logic [cache_pkg::BYTE_EN_WIDTH-1:0] dc_byte_w_en_in,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    data_reg,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    data_ram,
    input  logic                                ram_ready,
    output logic [cache_pkg::DATA_WIDTH-1:0]    ic_data_out,
    output logic [cache_pkg::DATA_WIDTH-1:0]    dc_data_out,
    output logic                                mem_stall,
    output logic                                ram_en_out,
    output logic                                ram_write_out,
    output logic [cache_pkg::ADDR_WIDTH-1:0]    ram_addr_out
);

    cache_pkg::cache_state_t  state;
    cache_pkg::cache_state_t  state_next;
    logic [OFFSET_WIDTH-1:0]  counter;
    logic [OFFSET_WIDTH-1:0]  counter_next;
    logic                     write_after_load;
    logic                     loading_ic;

    logic                                ic_enable, ic_cmp, ic_write, ic_data_sel, ic_valid_in;
    logic                                dc_enable, dc_cmp, dc_write, dc_data_sel, dc_valid_in;
    logic [OFFSET_WIDTH-1:0]             ic_word_sel, dc_word_sel;
    logic [cache_pkg::BYTE_EN_WIDTH-1:0] ic_byte_w_en, dc_byte_w_en;
    logic [cache_pkg::DATA_WIDTH-1:0]    ic_data_in, dc_data_in;
    logic [1:0]                          ram_addr_sel;
    logic                                ic_hit, ic_valid;
    logic                                dc_hit, dc_dirty, dc_valid;

    logic [TAG_WIDTH-1:0]    ic_tag, dc_tag, dc_tag_out;
    logic [INDEX_WIDTH-1:0]  ic_index, dc_index;
    logic [OFFSET_WIDTH-1:0] ic_offset, dc_offset;

    //////////////////////////////
    // Address split
    //////////////////////////////

    assign loading_ic = (state == cache_pkg::ST_IC_MISS) || (state == cache_pkg::ST_DOUBLE_MISS);

    assign ic_tag    = ic_addr[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    assign ic_index  = ic_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign ic_offset = ic_addr[OFFSET_WIDTH-1:0];
    // Data cache probes the instruction block during an instruction refill
    assign dc_tag    = loading_ic ? ic_tag : dc_addr[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    assign dc_index  = loading_ic ? ic_index : dc_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign dc_offset = dc_addr[OFFSET_WIDTH-1:0];

    always_comb begin
        case (ram_addr_sel)
            2'b10:   ram_addr_out = {dc_tag_out, dc_index, counter};
            2'b01:   ram_addr_out = {dc_tag, dc_index, counter};
            default: ram_addr_out = {ic_tag, ic_index, counter};
        endcase
    end

    // Fill sources
    assign ic_data_in = ic_data_sel ? data_ram : dc_data_out;
    assign dc_data_in = dc_data_sel ? data_ram : data_reg;

    //////////////////////////////
    // Controller and arrays
    //////////////////////////////

    cache_control #(
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) cctrl (
        .dc_read_in      (dc_read_in),
        .dc_write_in     (dc_write_in),
        .dc_byte_w_en_in (dc_byte_w_en_in),
        .ic_offset       (ic_offset),
        .dc_offset       (dc_offset),
        .ic_hit          (ic_hit),
        .ic_valid        (ic_valid),
        .dc_hit          (dc_hit),
        .dc_dirty        (dc_dirty),
        .dc_valid        (dc_valid),
        .state           (state),
        .counter         (counter),
        .ic_enable       (ic_enable),
        .ic_word_sel     (ic_word_sel),
        .ic_cmp          (ic_cmp),
        .ic_write        (ic_write),
        .ic_data_sel     (ic_data_sel),
        .ic_byte_w_en    (ic_byte_w_en),
        .ic_valid_in     (ic_valid_in),
        .dc_enable       (dc_enable),
        .dc_word_sel     (dc_word_sel),
        .dc_cmp          (dc_cmp),
        .dc_write        (dc_write),
        .dc_data_sel     (dc_data_sel),
        .dc_byte_w_en    (dc_byte_w_en),
        .dc_valid_in     (dc_valid_in),
        .ram_addr_sel    (ram_addr_sel),
        .ram_en_out      (ram_en_out),
        .ram_write_out   (ram_write_out),
        .state_next      (state_next),
        .counter_next    (counter_next)
    );

    // Instruction side never goes dirty, its victim tag is not needed
    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) ic (
        .clk       (clk),
        .rst       (rst),
        .enable    (ic_enable),
        .cmp       (ic_cmp),
        .write     (ic_write),
        .index     (ic_index),
        .word_sel  (ic_word_sel),
        .tag_in    (ic_tag),
        .data_in   (ic_data_in),
        .valid_in  (ic_valid_in),
        .byte_w_en (ic_byte_w_en),
        .hit       (ic_hit),
        .dirty     (),
        .tag_out   (),
        .data_out  (ic_data_out),
        .valid     (ic_valid)
    );

    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) dc (
        .clk       (clk),
        .rst       (rst),
        .enable    (dc_enable),
        .cmp       (dc_cmp),
        .write     (dc_write),
        .index     (dc_index),
        .word_sel  (dc_word_sel),
        .tag_in    (dc_tag),
        .data_in   (dc_data_in),
        .valid_in  (dc_valid_in),
        .byte_w_en (dc_byte_w_en),
        .hit       (dc_hit),
        .dirty     (dc_dirty),
        .tag_out   (dc_tag_out),
        .data_out  (dc_data_out),
        .valid     (dc_valid)
    );

    //////////////////////////////
    // Sequencer registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= cache_pkg::ST_NORMAL;
            counter          <= '1;
            write_after_load <= 1'b0;
        end else if (state == cache_pkg::ST_NORMAL) begin
            state            <= state_next;
            counter          <= counter_next;
            write_after_load <= 1'b0;
        end else begin
            // Store held across a refill replays once more as a hit
            if (dc_write_in) begin
                write_after_load <= 1'b1;
            end
            if (ram_ready || (loading_ic && dc_hit)) begin
                state   <= state_next;
                counter <= counter_next;
            end
        end
    end

    assign mem_stall = (state != cache_pkg::ST_NORMAL) || (state_next != cache_pkg::ST_NORMAL) ||
                       write_after_load;

    // Leaving normal needs a miss seen in the cycle before
    assert property (@(posedge clk) disable iff (rst)
        (state != cache_pkg::ST_NORMAL) && ($past(state) == cache_pkg::ST_NORMAL) |->
            $past(!ic_hit || ((dc_read_in || dc_write_in) && !dc_hit)));

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset drops just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== tb_cache_manage_unit.sv ====
`timescale 1ns/1ps

module tb_cache_manage_unit;

    localparam int OFFSET_WIDTH = 3;
    localparam int INDEX_WIDTH  = 6;
    // Modelled RAM covers the low 4K words
    localparam int RAM_AW       = 12;
    localparam int MAX_WAIT     = 400;

    typedef enum logic [1:0] {OP_NONE, OP_READ, OP_WRITE} data_op_t;

    typedef struct {
        string                               name;
        logic [cache_pkg::ADDR_WIDTH-1:0]    ic_addr;
        data_op_t                            op;
        logic [cache_pkg::ADDR_WIDTH-1:0]    dc_addr;
        logic [cache_pkg::DATA_WIDTH-1:0]    data;
        logic [cache_pkg::BYTE_EN_WIDTH-1:0] byte_en;
        int                                  ram_reads;
        int                                  ram_writes;
        logic [cache_pkg::ADDR_WIDTH-1:0]    wb_block;
    } row_t;

    logic                                clk;
    logic                                rst;
    logic [cache_pkg::ADDR_WIDTH-1:0]    ic_addr;
    logic [cache_pkg::ADDR_WIDTH-1:0]    dc_addr;
    logic                                dc_read_in;
    logic                                dc_write_in;
    logic [cache_pkg::BYTE_EN_WIDTH-1:0] dc_byte_w_en_in;
    logic [cache_pkg::DATA_WIDTH-1:0]    data_reg;
    logic [cache_pkg::DATA_WIDTH-1:0]    data_ram;
    logic                                ram_ready;
    logic [cache_pkg::DATA_WIDTH-1:0]    ic_data_out;
    logic [cache_pkg::DATA_WIDTH-1:0]    dc_data_out;
    logic                                mem_stall;
    logic                                ram_en_out;
    logic                                ram_write_out;
    logic [cache_pkg::ADDR_WIDTH-1:0]    ram_addr_out;

    logic [cache_pkg::DATA_WIDTH-1:0] ram_mem [1 << RAM_AW];
    logic [cache_pkg::DATA_WIDTH-1:0] shadow  [1 << RAM_AW];
    logic [31:0]                      rng_state;
    logic [1:0]                       ram_wait;
    int                               reads_seen;
    int                               writes_seen;
    int                               checks = 0;
    int                               errors = 0;
    string                            cur_name;
    logic [cache_pkg::ADDR_WIDTH-1:0] cur_wb_block;
    row_t                             rows[$];

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (2)
    ) clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    cache_manage_unit #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) cache_manage_unit_inst (
        .clk             (clk),
        .rst             (rst),
        .ic_addr         (ic_addr),
        .dc_addr         (dc_addr),
        .dc_read_in      (dc_read_in),
        .dc_write_in     (dc_write_in),
        .dc_byte_w_en_in (dc_byte_w_en_in),
        .data_reg        (data_reg),
        .data_ram        (data_ram),
        .ram_ready       (ram_ready),
        .ic_data_out     (ic_data_out),
        .dc_data_out     (dc_data_out),
        .mem_stall       (mem_stall),
        .ram_en_out      (ram_en_out),
        .ram_write_out   (ram_write_out),
        .ram_addr_out    (ram_addr_out)
    );

    //////////////////////////////
    // Helpers and checks
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Store semantics of the core, one enable per byte lane
    function automatic logic [cache_pkg::DATA_WIDTH-1:0] merge_bytes(
        input logic [cache_pkg::DATA_WIDTH-1:0]    old_word,
        input logic [cache_pkg::DATA_WIDTH-1:0]    new_word,
        input logic [cache_pkg::BYTE_EN_WIDTH-1:0] be
    );
        logic [cache_pkg::DATA_WIDTH-1:0] w;
        w = old_word;
        for (int b = 0; b < cache_pkg::BYTE_EN_WIDTH; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_word(input string name, input logic [cache_pkg::DATA_WIDTH-1:0] expected,
                              input logic [cache_pkg::DATA_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Victim words must land in the victim block and match the shadow copy
    task automatic check_ram_write(input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
                                   input logic [cache_pkg::DATA_WIDTH-1:0] data);
        checks++;
        if (addr[cache_pkg::ADDR_WIDTH-1:OFFSET_WIDTH] !==
            cur_wb_block[cache_pkg::ADDR_WIDTH-1:OFFSET_WIDTH]) begin
            errors++;
            $display("ERROR %s write-back block: expected %h, actual %h",
                     cur_name, cur_wb_block, addr);
        end
        checks++;
        if (data !== shadow[addr[RAM_AW-1:0]]) begin
            errors++;
            $display("ERROR %s write-back data at %h: expected %h, actual %h",
                     cur_name, addr, shadow[addr[RAM_AW-1:0]], data);
        end
    endtask

    task automatic wait_stall_low(output bit timed_out);
        int n;
        timed_out = 1'b1;
        n = 0;
        while (timed_out && n < MAX_WAIT) begin
            @(negedge clk);
            if (!mem_stall) begin
                timed_out = 1'b0;
            end
            n++;
        end
    endtask

    task automatic add_row(input string name, input logic [cache_pkg::ADDR_WIDTH-1:0] ic,
                           input data_op_t op, input logic [cache_pkg::ADDR_WIDTH-1:0] dc,
                           input logic [cache_pkg::DATA_WIDTH-1:0] data,
                           input logic [cache_pkg::BYTE_EN_WIDTH-1:0] be,
                           input int reads, input int writes,
                           input logic [cache_pkg::ADDR_WIDTH-1:0] wb_block);
        row_t r;
        r.name       = name;
        r.ic_addr    = ic;
        r.op         = op;
        r.dc_addr    = dc;
        r.data       = data;
        r.byte_en    = be;
        r.ram_reads  = reads;
        r.ram_writes = writes;
        r.wb_block   = wb_block;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Index 8 of the data cache takes blocks 0x040, 0x240 and 0x440
        add_row("cold_miss", 30'h101, OP_READ, 30'h043, 32'h0, 4'h0, 16, 0, 30'h0);
        add_row("hit_reread", 30'h105, OP_READ, 30'h046, 32'h0, 4'h0, 0, 0, 30'h0);
        add_row("byte_write", 30'h105, OP_WRITE, 30'h046, 32'hA5A5_1234, 4'b0101, 0, 0, 30'h0);
        add_row("merged_read", 30'h105, OP_READ, 30'h046, 32'h0, 4'h0, 0, 0, 30'h0);
        add_row("fill_other_way", 30'h106, OP_READ, 30'h243, 32'h0, 4'h0, 8, 0, 30'h0);
        add_row("evict_dirty", 30'h106, OP_READ, 30'h441, 32'h0, 4'h0, 8, 8, 30'h040);
        add_row("reload_victim", 30'h107, OP_READ, 30'h046, 32'h0, 4'h0, 8, 0, 30'h0);
        add_row("dirty_word", 30'h107, OP_WRITE, 30'h047, 32'h1357_9BDF, 4'hF, 0, 0, 30'h0);
        // Instruction block now sits dirty in the data cache
        add_row("fetch_from_dc", 30'h047, OP_NONE, 30'h0, 32'h0, 4'h0, 0, 0, 30'h0);
        add_row("double_miss", 30'h181, OP_READ, 30'h0C2, 32'h0, 4'h0, 16, 0, 30'h0);
        add_row("write_miss", 30'h181, OP_WRITE, 30'h0D5, 32'hCAFE_F00D, 4'b1100, 8, 0, 30'h0);
        add_row("read_after_miss", 30'h182, OP_READ, 30'h0D5, 32'h0, 4'h0, 0, 0, 30'h0);
    endtask

    //////////////////////////////
    // RAM model
    //////////////////////////////

    initial begin : ram_model
        logic [RAM_AW-1:0] a;
        ram_ready   = 1'b0;
        data_ram    = '0;
        reads_seen  = 0;
        writes_seen = 0;
        rng_state   = 32'h5044_9cd8;
        a           = '0;
        repeat (1 << RAM_AW) begin
            rng_state  = xorshift32(rng_state);
            ram_mem[a] = rng_state;
            a          = a + 1'b1;
        end
        ram_wait = 2'd0;
        forever begin
            @(posedge clk);
            #1;
            ram_ready = 1'b0;
            if (!rst && ram_en_out) begin
                if (ram_wait != 2'd0) begin
                    ram_wait = ram_wait - 2'd1;
                end else begin
                    if (ram_addr_out[cache_pkg::ADDR_WIDTH-1:RAM_AW] != '0) begin
                        errors++;
                        $display("RAM access at %h falls outside the modelled memory",
                                 ram_addr_out);
                    end else if (ram_write_out) begin
                        check_ram_write(ram_addr_out, dc_data_out);
                        ram_mem[ram_addr_out[RAM_AW-1:0]] = dc_data_out;
                        writes_seen++;
                    end else begin
                        data_ram = ram_mem[ram_addr_out[RAM_AW-1:0]];
                        reads_seen++;
                    end
                    ram_ready = 1'b1;
                    // Gap before the next word, 0 to 3 cycles
                    rng_state = xorshift32(rng_state);
                    ram_wait  = rng_state[1:0];
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        int   n;
        int   reads_base;
        int   writes_base;
        bit   timed_out;
        bit   released;
        row_t r;

        ic_addr         = '0;
        dc_addr         = '0;
        dc_read_in      = 1'b0;
        dc_write_in     = 1'b0;
        dc_byte_w_en_in = '0;
        data_reg        = '0;
        cur_name        = "reset";
        cur_wb_block    = '0;
        timed_out       = 1'b0;
        build_table();

        released = 1'b0;
        for (n = 0; n < MAX_WAIT && !released; n++) begin
            @(posedge clk);
            released = !rst;
        end
        if (!released) begin
            $display("Reset was not released within %0d cycles", MAX_WAIT);
            timed_out = 1'b1;
        end
        shadow = ram_mem;

        foreach (rows[i]) begin
            if (!timed_out) begin
                r = rows[i];
                #1;
                cur_name        = r.name;
                cur_wb_block    = r.wb_block;
                reads_base      = reads_seen;
                writes_base     = writes_seen;
                ic_addr         = r.ic_addr;
                dc_addr         = r.dc_addr;
                dc_read_in      = (r.op == OP_READ);
                dc_write_in     = (r.op == OP_WRITE);
                dc_byte_w_en_in = r.byte_en;
                data_reg        = r.data;
                wait_stall_low(timed_out);
                if (timed_out) begin
                    $display("mem_stall stayed high for %0d cycles in row %s", MAX_WAIT, r.name);
                end else begin
                    check_word($sformatf("%s ic", r.name), shadow[r.ic_addr[RAM_AW-1:0]],
                               ic_data_out);
                    if (r.op == OP_READ) begin
                        check_word($sformatf("%s dc", r.name), shadow[r.dc_addr[RAM_AW-1:0]],
                                   dc_data_out);
                    end
                    check_count($sformatf("%s ram reads", r.name), r.ram_reads,
                                reads_seen - reads_base);
                    check_count($sformatf("%s ram writes", r.name), r.ram_writes,
                                writes_seen - writes_base);
                    if (r.op == OP_WRITE) begin
                        shadow[r.dc_addr[RAM_AW-1:0]] =
                            merge_bytes(shadow[r.dc_addr[RAM_AW-1:0]], r.data, r.byte_en);
                    end
                    // Access completes at this edge
                    @(posedge clk);
                end
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== cache_manage_unit.f ====
cache_pkg.sv
cache_2ways.sv
cache_control.sv
cache_manage_unit.sv
tb_clock_gen.sv
tb_cache_manage_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cache_manage_unit.f \
    --top-module tb_cache_manage_unit -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
exit 1
